/* hw/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // ======================================================================
    // sizes
    // ======================================================================
    localparam int NUM_LANES    = 2;
    localparam int NUM_PHY_REGS = 64;
    localparam int NUM_ARCH_REGS = 32;
    localparam int PHY_W        = 6;
    localparam int ID_WIDTH     = 16;
    // slot count per cycle, 0..NUM_LANES
    localparam int CNT_W        = $clog2(NUM_LANES + 1);
    localparam int SLOT_W       = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    localparam logic [31:0] RESET_PC = 32'h0000_3000;
    localparam logic [4:0]  LINK_REG = 5'd31;

    // opcode and funct encodings of the supported subset
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;
    localparam logic [5:0] FN_JR       = 6'h08;
    localparam logic [5:0] FN_SYSCALL  = 6'h0c;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;

    // ======================================================================
    // types
    // ======================================================================
    typedef enum logic [3:0] {
        ALU_R, ORI, LUI, LW, SW, BEQ, J, JAL, JR, SYSCALL, OTHER
    } instr_class_t;

    typedef struct packed {
        instr_class_t cls;
        logic [4:0]   rs;
        logic [4:0]   rt;
        logic         rs_valid;
        logic         rt_valid;
        // only set when a nonzero register is written
        logic         has_dst;
        logic [4:0]   dst_lr;
        logic [25:0]  jidx;
    } decoded_t;

    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        logic [31:0]         next_pc;
        logic [ID_WIDTH-1:0] issue_id;
        instr_class_t        cls;
        logic [4:0]          dst_lr;
        logic                has_dst;
        logic [PHY_W-1:0]    phy_rs;
        logic [PHY_W-1:0]    phy_rt;
        logic [PHY_W-1:0]    phy_dst;
    } lane_packet_t;

    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        logic [ID_WIDTH-1:0] issue_id;
    } redirect_t;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
`default_nettype none

module instr_decoder (
    input  logic [31:0]         instr,
    output issue_pkg::decoded_t dec
);
    import issue_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       writes;
    logic [4:0] dst;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        dec      = '0;
        dec.rs   = instr[25:21];
        dec.rt   = instr[20:16];
        dec.jidx = instr[25:0];
        dec.cls  = OTHER;
        writes   = 1'b0;
        dst      = instr[20:16];
        case (opcode)
            OPC_SPECIAL: begin
                if (funct == FN_ADDU || funct == FN_SUBU) begin
                    dec.cls      = ALU_R;
                    dec.rs_valid = 1'b1;
                    dec.rt_valid = 1'b1;
                    writes       = 1'b1;
                    dst          = instr[15:11];
                end else if (funct == FN_JR) begin
                    dec.cls      = JR;
                    dec.rs_valid = 1'b1;
                end else if (funct == FN_SYSCALL) begin
                    dec.cls = SYSCALL;
                end
            end
            OPC_ORI: begin
                dec.cls      = ORI;
                dec.rs_valid = 1'b1;
                writes       = 1'b1;
            end
            OPC_LUI: begin
                dec.cls = LUI;
                writes  = 1'b1;
            end
            OPC_LW: begin
                dec.cls      = LW;
                dec.rs_valid = 1'b1;
                writes       = 1'b1;
            end
            OPC_SW: begin
                dec.cls      = SW;
                dec.rs_valid = 1'b1;
                dec.rt_valid = 1'b1;
            end
            // no predictor, BEQ only reads its sources
            OPC_BEQ: begin
                dec.cls      = BEQ;
                dec.rs_valid = 1'b1;
                dec.rt_valid = 1'b1;
            end
            OPC_J: begin
                dec.cls = J;
            end
            OPC_JAL: begin
                dec.cls = JAL;
                writes  = 1'b1;
                dst     = LINK_REG;
            end
            default: begin
                dec.cls = OTHER;
            end
        endcase
        // writes to $0 are dropped here so they never allocate
        dec.has_dst = writes && (dst != 5'd0);
        dec.dst_lr  = dec.has_dst ? dst : 5'd0;
    end

endmodule

`default_nettype wire

/* hw/fetch_sequencer.sv */
`default_nettype none

module fetch_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [issue_pkg::CNT_W-1:0]   issue_slots,
    input  logic                          jump_taken,
    input  logic [31:0]                   jump_target,
    input  logic                          jr_issued,
    input  issue_pkg::redirect_t          redirect,
    output logic [31:0]                   pc,
    output logic [issue_pkg::ID_WIDTH-1:0] base_id,
    output logic                          jr_waiting
);
    import issue_pkg::*;

    logic [ID_WIDTH-1:0] jr_wait_id;
    logic [ID_WIDTH-1:0] id_next;
    logic                redirect_hit;

    assign id_next = base_id + ID_WIDTH'(issue_slots);

    // only the redirect of the JR we stopped on releases the wait
    assign redirect_hit = redirect.valid && (redirect.issue_id == jr_wait_id);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= RESET_PC;
            base_id    <= '0;
            jr_waiting <= 1'b0;
            jr_wait_id <= '0;
        end else begin
            base_id <= id_next;
            if (jr_waiting) begin
                if (redirect_hit) begin
                    pc         <= redirect.pc;
                    jr_waiting <= 1'b0;
                end
            end else if (jr_issued) begin
                // JR always ends the window, so it sits in the last slot taken
                jr_waiting <= 1'b1;
                jr_wait_id <= id_next - ID_WIDTH'(1);
            end else if (jump_taken) begin
                pc <= jump_target;
            end else begin
                pc <= pc + 32'({issue_slots, 2'b00});
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rename_unit.sv */
`default_nettype none

module rename_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  issue_pkg::decoded_t             dec          [issue_pkg::NUM_LANES],
    input  logic                            lanes_quiet,
    input  logic [issue_pkg::CNT_W-1:0]     issue_slots,
    output logic [issue_pkg::PHY_W-1:0]     phy_rs       [issue_pkg::NUM_LANES],
    output logic [issue_pkg::PHY_W-1:0]     phy_rt       [issue_pkg::NUM_LANES],
    output logic [issue_pkg::PHY_W-1:0]     slot_phy_dst [issue_pkg::NUM_LANES],
    output logic [issue_pkg::NUM_LANES-1:0] alloc_ok
);
    import issue_pkg::*;

    // ======================================================================
    // architectural rename state
    // ======================================================================
    logic [PHY_W-1:0]        rat [NUM_ARCH_REGS];
    logic [NUM_PHY_REGS-1:0] free_map;
    // old mappings waiting for a quiet cycle
    logic [NUM_PHY_REGS-1:0] pend_map;

    // entry k is the state seen by slot k, entry NUM_LANES is after all slots
    logic [PHY_W-1:0]        rat_chain  [NUM_LANES+1][NUM_ARCH_REGS];
    logic [NUM_PHY_REGS-1:0] free_chain [NUM_LANES+1];
    logic [NUM_PHY_REGS-1:0] pend_chain [NUM_LANES+1];

    logic                    alloc_hit [NUM_LANES];
    logic [PHY_W-1:0]        alloc_pr  [NUM_LANES];
    logic [PHY_W-1:0]        old_pr    [NUM_LANES];

    // ======================================================================
    // allocation chain
    // ======================================================================
    always_comb begin
        // reclaim merge happens before any allocation of this cycle
        rat_chain[0]  = rat;
        free_chain[0] = lanes_quiet ? (free_map | pend_map) : free_map;
        pend_chain[0] = lanes_quiet ? '0 : pend_map;

        for (int k = 0; k < NUM_LANES; k++) begin
            // downward scan so the lowest free index wins
            alloc_hit[k] = 1'b0;
            alloc_pr[k]  = '0;
            for (int p = NUM_PHY_REGS - 1; p >= NUM_ARCH_REGS; p--) begin
                if (free_chain[k][p]) begin
                    alloc_hit[k] = 1'b1;
                    alloc_pr[k]  = PHY_W'(p);
                end
            end

            // sources see writes of earlier slots in this window
            phy_rs[k] = dec[k].rs_valid ? rat_chain[k][dec[k].rs] : '0;
            phy_rt[k] = dec[k].rt_valid ? rat_chain[k][dec[k].rt] : '0;
            old_pr[k] = rat_chain[k][dec[k].dst_lr];

            alloc_ok[k]     = !dec[k].has_dst || alloc_hit[k];
            slot_phy_dst[k] = (dec[k].has_dst && alloc_hit[k]) ? alloc_pr[k] : '0;

            rat_chain[k+1]  = rat_chain[k];
            free_chain[k+1] = free_chain[k];
            pend_chain[k+1] = pend_chain[k];
            if (dec[k].has_dst && alloc_hit[k]) begin
                // the identity range 0..31 is never handed back
                if (old_pr[k] >= PHY_W'(NUM_ARCH_REGS)) begin
                    pend_chain[k+1][old_pr[k]] = 1'b1;
                end
                rat_chain[k+1][dec[k].dst_lr] = alloc_pr[k];
                free_chain[k+1][alloc_pr[k]]  = 1'b0;
            end
        end
    end

    // commit the state left behind by the last slot issued
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                rat[r] <= PHY_W'(r);
            end
            free_map <= {{(NUM_PHY_REGS - NUM_ARCH_REGS){1'b1}}, {NUM_ARCH_REGS{1'b0}}};
            pend_map <= '0;
        end else begin
            rat      <= rat_chain[issue_slots];
            free_map <= free_chain[issue_slots];
            pend_map <= pend_chain[issue_slots];
        end
    end

endmodule

`default_nettype wire

/* hw/issue_select.sv */
`default_nettype none

module issue_select (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [issue_pkg::NUM_LANES-1:0]  lane_req,
    input  issue_pkg::decoded_t              dec          [issue_pkg::NUM_LANES],
    input  logic [31:0]                      pc,
    input  logic [issue_pkg::ID_WIDTH-1:0]   base_id,
    input  logic                             jr_waiting,
    input  logic [issue_pkg::PHY_W-1:0]      phy_rs       [issue_pkg::NUM_LANES],
    input  logic [issue_pkg::PHY_W-1:0]      phy_rt       [issue_pkg::NUM_LANES],
    input  logic [issue_pkg::PHY_W-1:0]      slot_phy_dst [issue_pkg::NUM_LANES],
    input  logic [issue_pkg::NUM_LANES-1:0]  alloc_ok,
    output logic [issue_pkg::CNT_W-1:0]      issue_slots,
    output logic                             jump_taken,
    output logic [31:0]                      jump_target,
    output logic                             jr_issued,
    output issue_pkg::lane_packet_t          lane_pkt     [issue_pkg::NUM_LANES]
);
    import issue_pkg::*;

    logic [31:0]          slot_pc   [NUM_LANES];
    logic [31:0]          slot_next [NUM_LANES];
    logic [NUM_LANES-1:0] grant;
    logic [SLOT_W-1:0]    lane_slot [NUM_LANES];
    logic [CNT_W-1:0]     cnt;
    logic                 stop;
    lane_packet_t         pkt_d     [NUM_LANES];

    // per-slot addresses
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            slot_pc[k] = pc + 32'(4 * k);
            case (dec[k].cls)
                J, JAL:  slot_next[k] = {slot_pc[k][31:28], dec[k].jidx, 2'b00};
                JR:      slot_next[k] = '0;
                default: slot_next[k] = slot_pc[k] + 32'd4;
            endcase
        end
    end

    // ======================================================================
    // lane scan in program order
    // ======================================================================
    always_comb begin
        cnt         = '0;
        stop        = jr_waiting;
        jump_taken  = 1'b0;
        jump_target = '0;
        jr_issued   = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            grant[l]     = 1'b0;
            lane_slot[l] = '0;
            if (!stop && lane_req[l]) begin
                if (!alloc_ok[cnt[SLOT_W-1:0]]) begin
                    // out of registers, window ends before this slot
                    stop = 1'b1;
                end else begin
                    grant[l]     = 1'b1;
                    lane_slot[l] = cnt[SLOT_W-1:0];
                    if (dec[cnt[SLOT_W-1:0]].cls inside {J, JAL}) begin
                        jump_taken  = 1'b1;
                        jump_target = slot_next[cnt[SLOT_W-1:0]];
                        stop        = 1'b1;
                    end else if (dec[cnt[SLOT_W-1:0]].cls == JR) begin
                        jr_issued = 1'b1;
                        stop      = 1'b1;
                    end
                    cnt = cnt + CNT_W'(1);
                end
            end
        end
        issue_slots = cnt;
    end

    // packet fields, zero where no slot was given
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            pkt_d[l] = '0;
            if (grant[l]) begin
                pkt_d[l].valid    = 1'b1;
                pkt_d[l].pc       = slot_pc[lane_slot[l]];
                pkt_d[l].next_pc  = slot_next[lane_slot[l]];
                pkt_d[l].issue_id = base_id + ID_WIDTH'(lane_slot[l]);
                pkt_d[l].cls      = dec[lane_slot[l]].cls;
                pkt_d[l].dst_lr   = dec[lane_slot[l]].dst_lr;
                pkt_d[l].has_dst  = dec[lane_slot[l]].has_dst;
                pkt_d[l].phy_rs   = phy_rs[lane_slot[l]];
                pkt_d[l].phy_rt   = phy_rt[lane_slot[l]];
                pkt_d[l].phy_dst  = slot_phy_dst[lane_slot[l]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_pkt[l] <= '0;
            end
        end else begin
            lane_pkt <= pkt_d;
        end
    end

endmodule

`default_nettype wire

/* hw/issue_top.sv */
`default_nettype none

module issue_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    output logic [31:0]                          imem_addr,
    input  logic [issue_pkg::NUM_LANES-1:0][31:0] imem_data,
    input  logic [issue_pkg::NUM_LANES-1:0]      lane_req,
    input  logic                                 lanes_quiet,
    input  issue_pkg::redirect_t                 redirect,
    output issue_pkg::lane_packet_t              lane_pkt [issue_pkg::NUM_LANES]
);
    import issue_pkg::*;

    decoded_t             dec          [NUM_LANES];
    logic [31:0]          pc;
    logic [ID_WIDTH-1:0]  base_id;
    logic                 jr_waiting;
    logic [PHY_W-1:0]     phy_rs       [NUM_LANES];
    logic [PHY_W-1:0]     phy_rt       [NUM_LANES];
    logic [PHY_W-1:0]     slot_phy_dst [NUM_LANES];
    logic [NUM_LANES-1:0] alloc_ok;
    logic [CNT_W-1:0]     issue_slots;
    logic                 jump_taken;
    logic [31:0]          jump_target;
    logic                 jr_issued;

    assign imem_addr = pc;

    // one decoder per fetch slot
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_dec
        instr_decoder u_dec (
            .instr (imem_data[k]),
            .dec   (dec[k])
        );
    end

    fetch_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_slots (issue_slots),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .jr_issued   (jr_issued),
        .redirect    (redirect),
        .pc          (pc),
        .base_id     (base_id),
        .jr_waiting  (jr_waiting)
    );

    rename_unit u_ren (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .lanes_quiet  (lanes_quiet),
        .issue_slots  (issue_slots),
        .phy_rs       (phy_rs),
        .phy_rt       (phy_rt),
        .slot_phy_dst (slot_phy_dst),
        .alloc_ok     (alloc_ok)
    );

    issue_select u_sel (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_req     (lane_req),
        .dec          (dec),
        .pc           (pc),
        .base_id      (base_id),
        .jr_waiting   (jr_waiting),
        .phy_rs       (phy_rs),
        .phy_rt       (phy_rt),
        .slot_phy_dst (slot_phy_dst),
        .alloc_ok     (alloc_ok),
        .issue_slots  (issue_slots),
        .jump_taken   (jump_taken),
        .jump_target  (jump_target),
        .jr_issued    (jr_issued),
        .lane_pkt     (lane_pkt)
    );

endmodule

`default_nettype wire

/* bench/issue_model.svh */
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH
`default_nettype none

// ======================================================================
// reference model state
// ======================================================================
logic [31:0]             m_pc;
logic [ID_WIDTH-1:0]     m_base_id;
logic                    m_jr_wait;
logic [ID_WIDTH-1:0]     m_jr_id;
logic [PHY_W-1:0]        m_rat [NUM_ARCH_REGS];
logic [NUM_PHY_REGS-1:0] m_free;
logic [NUM_PHY_REGS-1:0] m_pend;
lane_packet_t            exp_pkt [NUM_LANES];

task automatic reset_model();
    m_pc      = RESET_PC;
    m_base_id = '0;
    m_jr_wait = 1'b0;
    m_jr_id   = '0;
    m_free    = '0;
    m_pend    = '0;
    for (int r = 0; r < NUM_ARCH_REGS; r++) begin
        m_rat[r] = PHY_W'(r);
    end
    for (int p = NUM_ARCH_REGS; p < NUM_PHY_REGS; p++) begin
        m_free[p] = 1'b1;
    end
    for (int l = 0; l < NUM_LANES; l++) begin
        exp_pkt[l] = '0;
    end
endtask

// class first, then source use and destination follow from the class
function automatic decoded_t classify(input logic [31:0] w);
    decoded_t   d;
    logic [4:0] dst;
    d      = '0;
    d.rs   = w[25:21];
    d.rt   = w[20:16];
    d.jidx = w[25:0];
    d.cls  = OTHER;
    case (w[31:26])
        OPC_SPECIAL: begin
            if (w[5:0] == FN_ADDU || w[5:0] == FN_SUBU)
                d.cls = ALU_R;
            else if (w[5:0] == FN_JR)
                d.cls = JR;
            else if (w[5:0] == FN_SYSCALL)
                d.cls = SYSCALL;
        end
        OPC_ORI: d.cls = ORI;
        OPC_LUI: d.cls = LUI;
        OPC_LW:  d.cls = LW;
        OPC_SW:  d.cls = SW;
        OPC_BEQ: d.cls = BEQ;
        OPC_J:   d.cls = J;
        OPC_JAL: d.cls = JAL;
        default: d.cls = OTHER;
    endcase
    d.rs_valid = d.cls inside {ALU_R, ORI, LW, SW, BEQ, JR};
    d.rt_valid = d.cls inside {ALU_R, SW, BEQ};
    dst = (d.cls == ALU_R) ? w[15:11] : ((d.cls == JAL) ? LINK_REG : w[20:16]);
    d.has_dst = (d.cls inside {ALU_R, ORI, LUI, LW, JAL}) && (dst != 5'd0);
    d.dst_lr  = d.has_dst ? dst : 5'd0;
    return d;
endfunction

function automatic int lowest_free(input logic [NUM_PHY_REGS-1:0] map);
    for (int p = NUM_ARCH_REGS; p < NUM_PHY_REGS; p++) begin
        if (map[p])
            return p;
    end
    return -1;
endfunction

// one cycle of slot assignment, renaming and fetch/JR update
task automatic predict_cycle(input logic [NUM_LANES-1:0] req, input logic quiet,
                             input redirect_t rd);
    decoded_t         d;
    logic [31:0]      spc;
    logic [31:0]      target;
    logic [PHY_W-1:0] new_pr;
    int               pr;
    int               slot;
    logic             stop;
    logic             jumped;
    logic             jr_seen;
    slot    = 0;
    stop    = m_jr_wait;
    jumped  = 1'b0;
    jr_seen = 1'b0;
    target  = '0;
    // reclaim comes before this cycle's allocations
    if (quiet) begin
        m_free = m_free | m_pend;
        m_pend = '0;
    end
    for (int l = 0; l < NUM_LANES; l++) begin
        exp_pkt[l] = '0;
        if (!stop && req[l]) begin
            spc = m_pc + 32'(4 * slot);
            d   = classify(fetch_word(spc));
            pr  = d.has_dst ? lowest_free(m_free) : 0;
            if (pr < 0) begin
                stop = 1'b1;
            end else begin
                new_pr                = PHY_W'(pr);
                exp_pkt[l].valid      = 1'b1;
                exp_pkt[l].pc         = spc;
                exp_pkt[l].issue_id   = m_base_id + ID_WIDTH'(slot);
                exp_pkt[l].cls        = d.cls;
                exp_pkt[l].dst_lr     = d.dst_lr;
                exp_pkt[l].has_dst    = d.has_dst;
                exp_pkt[l].phy_rs     = d.rs_valid ? m_rat[d.rs] : '0;
                exp_pkt[l].phy_rt     = d.rt_valid ? m_rat[d.rt] : '0;
                if (d.cls == J || d.cls == JAL) begin
                    target             = {spc[31:28], d.jidx, 2'b00};
                    exp_pkt[l].next_pc = target;
                    jumped             = 1'b1;
                    stop               = 1'b1;
                end else if (d.cls == JR) begin
                    exp_pkt[l].next_pc = '0;
                    jr_seen            = 1'b1;
                    stop               = 1'b1;
                end else begin
                    exp_pkt[l].next_pc = spc + 32'd4;
                end
                if (d.has_dst) begin
                    if (m_rat[d.dst_lr] >= PHY_W'(NUM_ARCH_REGS))
                        m_pend[m_rat[d.dst_lr]] = 1'b1;
                    exp_pkt[l].phy_dst = new_pr;
                    m_rat[d.dst_lr]    = new_pr;
                    m_free[new_pr]     = 1'b0;
                end
                slot++;
            end
        end
    end
    if (m_jr_wait) begin
        if (rd.valid && rd.issue_id == m_jr_id) begin
            m_pc      = rd.pc;
            m_jr_wait = 1'b0;
        end
    end else if (jr_seen) begin
        m_jr_wait = 1'b1;
        m_jr_id   = m_base_id + ID_WIDTH'(slot - 1);
    end else if (jumped) begin
        m_pc = target;
    end else begin
        m_pc = m_pc + 32'(4 * slot);
    end
    m_base_id = m_base_id + ID_WIDTH'(slot);
endtask

`default_nettype wire
`endif

/* bench/issue_tb.sv */
`default_nettype none

module issue_tb;
    import issue_pkg::*;

    localparam int          IMEM_AW       = 10;
    localparam int          IMEM_DEPTH    = 1 << IMEM_AW;
    localparam int          NUM_CYCLES    = 3000;
    localparam int          JR_TIMEOUT    = 40;
    // after this many waiting cycles the matching redirect is always sent
    localparam int          FORCE_RELEASE = 12;
    localparam logic [31:0] SEED          = 32'h1f6c;

    logic                          clk;
    logic                          rst_n;
    logic [31:0]                   imem_addr;
    logic [NUM_LANES-1:0][31:0]    imem_data;
    logic [NUM_LANES-1:0]          lane_req;
    logic                          lanes_quiet;
    redirect_t                     redirect;
    lane_packet_t                  lane_pkt [NUM_LANES];

    logic [31:0] imem [IMEM_DEPTH];
    int          mismatches;
    int          timeouts;
    int          checks;
    int          cycle;

    // program memory repeats every 4 KB of address space
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        return imem[addr[IMEM_AW+1:2]];
    endfunction

    `include "issue_model.svh"

    issue_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .lane_req    (lane_req),
        .lanes_quiet (lanes_quiet),
        .redirect    (redirect),
        .lane_pkt    (lane_pkt)
    );

    always #50 clk = ~clk;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            imem_data[k] = fetch_word(imem_addr + 32'(4 * k));
        end
    end

    // ======================================================================
    // random program
    // ======================================================================
    function automatic logic [4:0] pick_reg();
        // a small pool makes same-window dependences common
        if ($urandom_range(1, 0) == 0)
            return 5'($urandom_range(7, 0));
        return 5'($urandom_range(31, 0));
    endfunction

    function automatic logic [31:0] jump_address();
        return RESET_PC + 32'(4 * $urandom_range(IMEM_DEPTH - 1, 0));
    endfunction

    function automatic logic [31:0] make_instr();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] tgt;
        int unsigned pick;
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        imm  = 16'($urandom);
        tgt  = jump_address();
        pick = $urandom_range(99, 0);
        if (pick < 22)
            return {OPC_SPECIAL, rs, rt, rd, 5'd0, (pick[0] ? FN_ADDU : FN_SUBU)};
        else if (pick < 34)
            return {OPC_ORI, rs, rt, imm};
        else if (pick < 42)
            return {OPC_LUI, 5'd0, rt, imm};
        else if (pick < 54)
            return {OPC_LW, rs, rt, imm};
        else if (pick < 64)
            return {OPC_SW, rs, rt, imm};
        else if (pick < 72)
            return {OPC_BEQ, rs, rt, imm};
        else if (pick < 80)
            return {OPC_J, tgt[27:2]};
        else if (pick < 86)
            return {OPC_JAL, tgt[27:2]};
        else if (pick < 92)
            return {OPC_SPECIAL, rs, 15'd0, FN_JR};
        return {OPC_SPECIAL, 20'd0, FN_SYSCALL};
    endfunction

    // ======================================================================
    // per-cycle stimulus and checks
    // ======================================================================
    task automatic check_outputs();
        for (int l = 0; l < NUM_LANES; l++) begin
            checks++;
            assert (lane_pkt[l] === exp_pkt[l]) else begin
                mismatches++;
                $display("mismatch at %0t: lane %0d packet %h, expected %h",
                         $time, l, lane_pkt[l], exp_pkt[l]);
            end
        end
        checks++;
        assert (imem_addr === m_pc) else begin
            mismatches++;
            $display("mismatch at %0t: fetch address %h, expected %h", $time, imem_addr, m_pc);
        end
    endtask

    task automatic run_cycle(input int waited);
        logic [NUM_LANES-1:0] req;
        logic                 quiet;
        redirect_t            rd;
        for (int l = 0; l < NUM_LANES; l++) begin
            req[l] = ($urandom_range(3, 0) != 0);
        end
        // long busy stretches run the free list dry
        if (((cycle / 200) % 2) == 0)
            quiet = ($urandom_range(3, 0) == 0);
        else
            quiet = ($urandom_range(31, 0) == 0);
        rd = '0;
        if (m_jr_wait) begin
            if (waited >= FORCE_RELEASE || $urandom_range(3, 0) == 0) begin
                rd.valid    = 1'b1;
                rd.pc       = jump_address();
                rd.issue_id = m_jr_id;
                if (waited < FORCE_RELEASE && $urandom_range(2, 0) == 0)
                    rd.issue_id = m_jr_id + ID_WIDTH'($urandom_range(8, 1));
            end
        end else if ($urandom_range(15, 0) == 0) begin
            rd.valid    = 1'b1;
            rd.pc       = jump_address();
            rd.issue_id = ID_WIDTH'($urandom);
        end
        lane_req    = req;
        lanes_quiet = quiet;
        redirect    = rd;
        predict_cycle(req, quiet, rd);
        @(negedge clk);
        check_outputs();
        cycle++;
    endtask

    task automatic wait_jr_release();
        int w;
        w = 0;
        while (m_jr_wait && w < JR_TIMEOUT) begin
            run_cycle(w);
            w++;
        end
        if (m_jr_wait) begin
            timeouts++;
            $display("timeout: a JR was still waiting for its redirect after %0d cycles",
                     JR_TIMEOUT);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        lane_req    = '0;
        lanes_quiet = 1'b0;
        redirect    = '0;
        mismatches  = 0;
        timeouts    = 0;
        checks      = 0;
        cycle       = 0;
        void'($urandom(SEED));
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = make_instr();
        end
        reset_model();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        while (cycle < NUM_CYCLES && timeouts == 0) begin
            run_cycle(0);
            if (m_jr_wait)
                wait_jr_release();
        end
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
hw/issue_pkg.sv
hw/instr_decoder.sv
hw/fetch_sequencer.sv
hw/rename_unit.sv
hw/issue_select.sv
hw/issue_top.sv
bench/issue_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= issue_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Everything OK" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
